// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/core_stimulus.txt ====
# test(dec) instr pc_next trigger cache_en | exp alu_out eq a0 hits, all hex
# alu_out and eq hold in the same cycle, a0 and hits after the next rising edge
1 12300093 00000000 0 0 00000123 0 00000000 0000
1 00508513 00000000 0 0 00000128 0 00000128 0000
1 FFF00113 00000000 0 0 FFFFFFFF 0 00000128 0000
1 123451B7 00000000 0 0 12345000 0 00000128 0000
1 00308533 00000000 0 0 12345123 0 12345123 0000
1 40208533 00000000 0 0 00000124 0 00000124 0000
1 0021F533 00000000 0 0 12345000 0 12345000 0000
1 0030E533 00000000 0 0 12345123 0 12345123 0000
1 00114533 00000000 0 0 FFFFFEDC 0 FFFFFEDC 0000
1 00112533 00000000 0 0 00000001 0 00000001 0000
1 00400213 00000000 0 0 00000004 0 00000001 0000
1 00409533 00000000 0 0 00001230 0 00001230 0000
1 0041D533 00000000 0 0 01234500 0 01234500 0000
2 00108463 00000000 0 0 00000000 1 01234500 0000
2 00308463 00000000 0 0 EDCBB123 0 01234500 0000
3 0100056F 00000104 0 0 00000010 0 00000104 0000
4 02000313 00000000 0 0 00000020 0 00000104 0000
4 06000393 00000000 0 0 00000060 0 00000104 0000
4 A1B2C437 00000000 0 0 A1B2C000 0 00000104 0000
4 3D440413 00000000 0 0 A1B2C3D4 0 00000104 0000
4 00832023 00000000 0 1 00000020 0 00000104 0000
4 00032503 00000000 0 1 00000020 0 A1B2C3D4 0001
4 00134503 00000000 0 1 00000021 0 000000C3 0002
4 00830123 00000000 0 1 00000022 0 000000C3 0002
4 00032503 00000000 0 1 00000020 0 A1D4C3D4 0003
4 0013A023 00000000 0 1 00000060 0 A1D4C3D4 0003
4 00032503 00000000 0 1 00000020 0 A1D4C3D4 0003
4 0003A503 00000000 0 1 00000060 0 00000123 0003
4 0003A503 00000000 0 1 00000060 0 00000123 0004
5 0083A023 00000000 0 0 00000060 0 00000123 0004
5 0033C503 00000000 0 0 00000063 0 000000A1 0004
5 0003A503 00000000 0 1 00000060 0 A1B2C3D4 0004
5 0003A503 00000000 0 1 00000060 0 A1B2C3D4 0005
5 00032503 00000000 0 0 00000020 0 A1D4C3D4 0005
6 00000013 00000000 1 0 00000000 1 A1D4C3D4 0005
6 00028533 00000000 0 0 00000001 0 00000001 0005
6 00000293 00000000 1 0 00000000 1 00000001 0005
6 00528533 00000000 0 0 00000002 1 00000002 0005
6 00000293 00000000 0 0 00000000 1 00000002 0005
6 00528533 00000000 0 0 00000000 1 00000000 0005

// ==== dv/tb_core_top.sv ====
`timescale 1ns/10ps

module tb_core_top;

    localparam int    RESET_CYCLES  = 4;
    localparam int    TIMEOUT_SLACK = 20;
    localparam string STIM_FILE     = "dv/core_stimulus.txt";
    localparam core_pkg::instr_t NOP = 32'h0000_0013;    // addi x0, x0, 0

    // one line of the stimulus file
    typedef struct packed {
        logic [31:0]            test;
        core_pkg::instr_t       instr;
        core_pkg::word_t        pc_next;
        logic                   trigger;
        logic                   cache_enable;
        core_pkg::word_t        exp_alu;
        logic                   exp_eq;
        core_pkg::word_t        exp_a0;
        core_pkg::hit_count_t   exp_hits;
    } stim_row_t;

    logic                   clk;
    logic                   rst_n;
    core_pkg::instr_t       instr;
    core_pkg::word_t        pc_next;
    logic                   trigger;
    logic                   cache_enable;
    logic                   eq;
    core_pkg::word_t        a0;
    core_pkg::word_t        alu_out;
    core_pkg::hit_count_t   cache_hits;

    stim_row_t  rows [$];
    int         cycle_count = 0;
    int         cycle_limit = RESET_CYCLES + TIMEOUT_SLACK;    // raised once rows are known
    int         pass_count  = 0;
    int         fail_count  = 0;
    int         test_errors = 0;
    int         bad_lines   = 0;

    core_top UUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .instr_i        (instr),
        .pc_next_i      (pc_next),
        .trigger_i      (trigger),
        .cache_enable_i (cache_enable),
        .eq_o           (eq),
        .a0_o           (a0),
        .alu_out_o      (alu_out),
        .cache_hits_o   (cache_hits)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not end within %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic load_rows(output bit opened);
        int             fd;
        int             fields;
        string          line;
        logic [31:0]    f_test, f_instr, f_pc, f_trig, f_ce;
        logic [31:0]    f_alu, f_eq, f_a0, f_hits;
        stim_row_t      row;
        opened = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            opened = 1'b1;
            while ($fgets(line, fd) > 0) begin
                fields = $sscanf(line, "%d %h %h %h %h %h %h %h %h", f_test, f_instr, f_pc,
                                 f_trig, f_ce, f_alu, f_eq, f_a0, f_hits);
                if (fields == 9) begin
                    row.test         = f_test;
                    row.instr        = f_instr;
                    row.pc_next      = f_pc;
                    row.trigger      = f_trig[0];
                    row.cache_enable = f_ce[0];
                    row.exp_alu      = f_alu;
                    row.exp_eq       = f_eq[0];
                    row.exp_a0       = f_a0;
                    row.exp_hits     = f_hits[15:0];
                    rows.push_back(row);
                end else if (fields > 0) begin   // comment lines parse to nothing
                    $display("stimulus line could not be read: %s", line);
                    bad_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic close_test(input int test_num);
        if (test_errors == 0) begin
            $display("test %0d PASS", test_num);
            pass_count++;
        end else begin
            $display("test %0d FAIL with %0d mismatches", test_num, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    // one row per cycle starting on a falling edge
    task automatic apply_rows();
        stim_row_t  row;
        int         current_test;
        current_test = rows[0].test;
        foreach (rows[i]) begin
            row = rows[i];
            if (row.test != current_test) begin
                close_test(current_test);
                current_test = row.test;
            end
            instr        = row.instr;
            pc_next      = row.pc_next;
            trigger      = row.trigger;
            cache_enable = row.cache_enable;
            #1;     // let the combinational path settle
            if (alu_out !== row.exp_alu) begin
                $display("[ERROR] test %0d row %0d alu_out_o expected 0x%08h got 0x%08h",
                         row.test, i, row.exp_alu, alu_out);
                test_errors++;
            end
            if (eq !== row.exp_eq) begin
                $display("[ERROR] test %0d row %0d eq_o expected 0x%0h got 0x%0h",
                         row.test, i, row.exp_eq, eq);
                test_errors++;
            end
            @(negedge clk);
            // state written at the rising edge in between
            if (a0 !== row.exp_a0) begin
                $display("[ERROR] test %0d row %0d a0_o expected 0x%08h got 0x%08h",
                         row.test, i, row.exp_a0, a0);
                test_errors++;
            end
            if (cache_hits !== row.exp_hits) begin
                $display("[ERROR] test %0d row %0d cache_hits_o expected 0x%04h got 0x%04h",
                         row.test, i, row.exp_hits, cache_hits);
                test_errors++;
            end
        end
        close_test(current_test);
        instr        = NOP;
        trigger      = 1'b0;
        cache_enable = 1'b0;
    endtask

    initial begin
        bit opened;
        rst_n        = 1'b0;
        instr        = NOP;
        pc_next      = '0;
        trigger      = 1'b0;
        cache_enable = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        load_rows(opened);
        if (!opened) begin
            $display("the stimulus file %s could not be opened", STIM_FILE);
            $display("Simulation failed");
        end else begin
            cycle_limit = RESET_CYCLES + 2 * rows.size() + TIMEOUT_SLACK;
            if (rows.size() > 0) begin
                apply_rows();
            end else begin
                $display("the stimulus file holds no test rows");
            end
            $display("tests passed %0d failed %0d", pass_count, fail_count);
            if (fail_count == 0 && bad_lines == 0 && rows.size() > 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/core_pkg.sv
verilog/control_decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/data_cache.sv
verilog/data_memory.sv
verilog/datapath.sv
verilog/core_top.sv
dv/tb_core_top.sv

// ==== verilog/alu.sv ====
`timescale 1ns/10ps

module alu (
    input   core_pkg::word_t    src1_i,
    input   core_pkg::word_t    src2_i,
    input   core_pkg::alu_op_e  alu_control_i,
    output  logic               eq_o,
    output  core_pkg::word_t    alu_result_o
);

    logic   [4:0]   shamt;

    assign shamt = src2_i[4:0];

    // independent of the op so beq sees it under sub
    assign eq_o = (src1_i == src2_i);

    always_comb begin
        case (alu_control_i)
            core_pkg::ALU_ADD: alu_result_o = src1_i + src2_i;
            core_pkg::ALU_SUB: alu_result_o = src1_i - src2_i;
            core_pkg::ALU_AND: alu_result_o = src1_i & src2_i;
            core_pkg::ALU_OR:  alu_result_o = src1_i | src2_i;
            core_pkg::ALU_XOR: alu_result_o = src1_i ^ src2_i;
            core_pkg::ALU_SLT: begin
                alu_result_o = core_pkg::word_t'($signed(src1_i) < $signed(src2_i));
            end
            core_pkg::ALU_SLL: alu_result_o = src1_i << shamt;
            core_pkg::ALU_SRL: alu_result_o = src1_i >> shamt;     // logical
            default:           alu_result_o = '0;
        endcase
    end

endmodule

// ==== verilog/control_decoder.sv ====
`timescale 1ns/10ps

module control_decoder (
    input   core_pkg::instr_t   instr_i,
    output  core_pkg::ctrl_t    ctrl_o,
    output  core_pkg::word_t    imm_ext_o
);

    core_pkg::opcode_e  opcode;
    logic   [2:0]       funct3;
    logic               funct7_b5;
    core_pkg::word_t    imm_i, imm_s, imm_b, imm_u, imm_j;

    function automatic core_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic sub);
        core_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = sub ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'b001:  op = core_pkg::ALU_SLL;
            3'b010:  op = core_pkg::ALU_SLT;
            3'b100:  op = core_pkg::ALU_XOR;
            3'b101:  op = core_pkg::ALU_SRL;
            3'b110:  op = core_pkg::ALU_OR;
            3'b111:  op = core_pkg::ALU_AND;
            default: op = core_pkg::ALU_ADD;    // sltu not in the subset
        endcase
        return op;
    endfunction

    assign opcode    = core_pkg::opcode_e'(instr_i[6:0]);
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    // immediates by instruction format
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};     // no sign extension
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        ctrl_o             = '0;
        ctrl_o.rs1         = instr_i[19:15];
        ctrl_o.rs2         = instr_i[24:20];
        ctrl_o.rd          = instr_i[11:7];
        ctrl_o.result_src  = core_pkg::RES_ALU;
        ctrl_o.alu_control = core_pkg::ALU_ADD;
        imm_ext_o          = '0;

        case (opcode)
            core_pkg::OP_R: begin
                ctrl_o.reg_we      = 1'b1;
                ctrl_o.alu_control = alu_decode(funct3, funct7_b5);
            end
            core_pkg::OP_IMM: begin
                ctrl_o.reg_we      = 1'b1;
                ctrl_o.alu_src     = 1'b1;
                ctrl_o.alu_control = alu_decode(funct3, 1'b0);
                imm_ext_o          = imm_i;
            end
            core_pkg::OP_LOAD: begin
                // only lw (010) and lbu (100)
                ctrl_o.reg_we      = (funct3 == 3'b010) || (funct3 == 3'b100);
                ctrl_o.alu_src     = 1'b1;
                ctrl_o.result_src  = core_pkg::RES_MEM;
                ctrl_o.mem_byte_op = funct3[2];
                imm_ext_o          = imm_i;
            end
            core_pkg::OP_STORE: begin
                ctrl_o.mem_we      = (funct3 == 3'b000) || (funct3 == 3'b010);
                ctrl_o.alu_src     = 1'b1;
                ctrl_o.mem_byte_op = (funct3 == 3'b000);   // sb
                imm_ext_o          = imm_s;
            end
            core_pkg::OP_BRANCH: begin
                ctrl_o.alu_control = core_pkg::ALU_SUB;     // beq compare only
                imm_ext_o          = imm_b;
            end
            core_pkg::OP_LUI: begin
                ctrl_o.rs1        = '0;   // alu passes the immediate through
                ctrl_o.reg_we     = 1'b1;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = core_pkg::RES_IMM;
                imm_ext_o         = imm_u;
            end
            core_pkg::OP_JAL: begin
                ctrl_o.rs1        = '0;
                ctrl_o.reg_we     = 1'b1;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = core_pkg::RES_PC_NEXT;
                imm_ext_o         = imm_j;
            end
            default: ;  // unknown opcode writes nothing
        endcase
    end

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

    localparam int DATA_WIDTH      = 32;
    localparam int REG_ADDR_LENGTH = 5;
    localparam int BYTE_WIDTH      = 8;
    localparam int CACHE_LINES     = 16;
    localparam int MEM_WORDS       = 256;

    // derived geometry
    localparam int NUM_BYTES      = DATA_WIDTH / BYTE_WIDTH;
    localparam int OFFSET_WIDTH   = $clog2(NUM_BYTES);
    localparam int INDEX_WIDTH    = $clog2(CACHE_LINES);
    localparam int TAG_WIDTH      = DATA_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_WORDS);

    typedef logic [DATA_WIDTH-1:0]      word_t;
    typedef logic [REG_ADDR_LENGTH-1:0] reg_addr_t;
    typedef logic [DATA_WIDTH-1:0]      instr_t;
    typedef logic [15:0]                hit_count_t;
    typedef logic [NUM_BYTES-1:0]       byte_en_t;
    typedef logic [INDEX_WIDTH-1:0]     cache_index_t;
    typedef logic [TAG_WIDTH-1:0]       cache_tag_t;
    typedef logic [MEM_ADDR_WIDTH-1:0]  mem_addr_t;

    localparam reg_addr_t T0_REG = 5'd5;    // trigger flag lives here
    localparam reg_addr_t A0_REG = 5'd10;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU     = 2'd0,
        RES_MEM     = 2'd1,
        RES_PC_NEXT = 2'd2,
        RES_IMM     = 2'd3
    } result_src_e;

    typedef struct packed {
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        logic        reg_we;
        result_src_e result_src;
        alu_op_e     alu_control;
        logic        alu_src;       // 1 selects the immediate
        logic        mem_we;
        logic        mem_byte_op;
    } ctrl_t;

    typedef struct packed {
        logic     we;
        logic     byte_op;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } mem_req_t;

endpackage

// ==== verilog/core_top.sv ====
`timescale 1ns/10ps

module core_top (
    input   logic                   clk_i,
    input   logic                   rst_n_i,
    input   core_pkg::instr_t       instr_i,
    input   core_pkg::word_t        pc_next_i,
    input   logic                   trigger_i,
    input   logic                   cache_enable_i,
    output  logic                   eq_o,
    output  core_pkg::word_t        a0_o,
    output  core_pkg::word_t        alu_out_o,
    output  core_pkg::hit_count_t   cache_hits_o
);

    core_pkg::ctrl_t    ctrl;
    core_pkg::word_t    imm_ext;

    control_decoder core_control_decoder (
        .instr_i   (instr_i),
        .ctrl_o    (ctrl),
        .imm_ext_o (imm_ext)
    );

    datapath core_datapath (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ctrl_i         (ctrl),
        .imm_ext_i      (imm_ext),
        .pc_next_i      (pc_next_i),
        .trigger_i      (trigger_i),
        .cache_enable_i (cache_enable_i),
        .eq_o           (eq_o),
        .a0_o           (a0_o),
        .alu_out_o      (alu_out_o),
        .cache_hits_o   (cache_hits_o)
    );

endmodule

// ==== verilog/data_cache.sv ====
`timescale 1ns/10ps

module data_cache (
    input   logic                   clk_i,
    input   logic                   rst_n_i,
    input   logic                   cache_enable_i,
    input   logic                   write_enable_i,
    input   logic                   byte_op_i,
    input   core_pkg::word_t        address_i,
    input   core_pkg::word_t        write_data_i,
    output  core_pkg::word_t        read_data_o,
    output  core_pkg::mem_req_t     mem_req_o,
    input   core_pkg::word_t        mem_rdata_i,
    output  core_pkg::hit_count_t   hits_o
);

    localparam int IDX_LO = core_pkg::OFFSET_WIDTH;
    localparam int TAG_LO = core_pkg::OFFSET_WIDTH + core_pkg::INDEX_WIDTH;

    core_pkg::cache_tag_t   tags  [core_pkg::CACHE_LINES];
    core_pkg::word_t        lines [core_pkg::CACHE_LINES];
    logic   [core_pkg::CACHE_LINES-1:0] valid;

    core_pkg::cache_index_t index;
    core_pkg::cache_tag_t   tag;
    logic   [core_pkg::OFFSET_WIDTH-1:0] lane;
    core_pkg::byte_en_t     byte_en;
    core_pkg::word_t        store_word;     // byte replicated over all lanes
    core_pkg::word_t        merged_line;
    core_pkg::word_t        load_word;
    logic                   tag_hit;
    logic                   load_hit;
    logic                   fill_en;
    logic                   line_wr_en;
    logic                   inval_en;

    assign index = address_i[TAG_LO-1:IDX_LO];
    assign tag   = address_i[core_pkg::DATA_WIDTH-1:TAG_LO];
    assign lane  = address_i[IDX_LO-1:0];

    assign byte_en    = byte_op_i ? core_pkg::byte_en_t'(1) << lane : '1;
    assign store_word = byte_op_i ? {core_pkg::NUM_BYTES{write_data_i[core_pkg::BYTE_WIDTH-1:0]}}
                                  : write_data_i;

    assign tag_hit  = valid[index] && (tags[index] == tag);
    assign load_hit = !write_enable_i && cache_enable_i && tag_hit;

    // what changes at the edge
    assign fill_en    = !write_enable_i && cache_enable_i && !tag_hit;
    assign line_wr_en = write_enable_i && cache_enable_i && (!byte_op_i || tag_hit);
    assign inval_en   = write_enable_i && !cache_enable_i && tag_hit;

    always_comb begin
        for (int b = 0; b < core_pkg::NUM_BYTES; b++) begin
            merged_line[b*core_pkg::BYTE_WIDTH +: core_pkg::BYTE_WIDTH] = byte_en[b]
                ? store_word[b*core_pkg::BYTE_WIDTH +: core_pkg::BYTE_WIDTH]
                : lines[index][b*core_pkg::BYTE_WIDTH +: core_pkg::BYTE_WIDTH];
        end
    end

    // memory sees every store through this request
    assign mem_req_o.we      = write_enable_i && rst_n_i;
    assign mem_req_o.byte_op = byte_op_i;
    assign mem_req_o.addr    = address_i;
    assign mem_req_o.wdata   = write_data_i;
    assign mem_req_o.byte_en = byte_en;

    assign load_word = load_hit ? lines[index] : mem_rdata_i;

    always_comb begin
        if (byte_op_i)  // lbu zero extends
            read_data_o = core_pkg::word_t'(load_word >> (lane * core_pkg::BYTE_WIDTH))
                          & core_pkg::word_t'({core_pkg::BYTE_WIDTH{1'b1}});
        else
            read_data_o = load_word;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid  <= '0;
            hits_o <= '0;
        end else begin
            if (fill_en || line_wr_en) valid[index] <= 1'b1;
            if (inval_en)              valid[index] <= 1'b0;
            if (load_hit)              hits_o <= hits_o + 1'b1;   // wraps
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_en) begin
            lines[index] <= mem_rdata_i;
            tags[index]  <= tag;
        end else if (line_wr_en) begin
            lines[index] <= merged_line;
            tags[index]  <= tag;
        end
    end

endmodule

// ==== verilog/data_memory.sv ====
`timescale 1ns/10ps

module data_memory (
    input   logic                   clk_i,
    input   core_pkg::mem_req_t     mem_req_i,
    output  core_pkg::word_t        rdata_o
);

    core_pkg::word_t    mem [core_pkg::MEM_WORDS];

    core_pkg::mem_addr_t    word_addr;
    core_pkg::word_t        lane_data;

    // word index wraps modulo the array size
    assign word_addr = mem_req_i.addr[core_pkg::MEM_ADDR_WIDTH+core_pkg::OFFSET_WIDTH-1:
                                      core_pkg::OFFSET_WIDTH];

    // a byte store puts its low byte on every lane
    assign lane_data = mem_req_i.byte_op
                     ? {core_pkg::NUM_BYTES{mem_req_i.wdata[core_pkg::BYTE_WIDTH-1:0]}}
                     : mem_req_i.wdata;

    always_ff @(posedge clk_i) begin
        if (mem_req_i.we) begin
            for (int b = 0; b < core_pkg::NUM_BYTES; b++) begin
                if (mem_req_i.byte_en[b])
                    mem[word_addr][b*core_pkg::BYTE_WIDTH +: core_pkg::BYTE_WIDTH] <=
                        lane_data[b*core_pkg::BYTE_WIDTH +: core_pkg::BYTE_WIDTH];
            end
        end
    end

    assign rdata_o = mem[word_addr];    // async read

endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/10ps

module datapath (
    input   logic                   clk_i,
    input   logic                   rst_n_i,
    input   core_pkg::ctrl_t        ctrl_i,
    input   core_pkg::word_t        imm_ext_i,
    input   core_pkg::word_t        pc_next_i,
    input   logic                   trigger_i,
    input   logic                   cache_enable_i,
    output  logic                   eq_o,
    output  core_pkg::word_t        a0_o,
    output  core_pkg::word_t        alu_out_o,
    output  core_pkg::hit_count_t   cache_hits_o
);

    core_pkg::word_t    reg_rd1, reg_rd2;
    core_pkg::word_t    reg_wd;
    core_pkg::word_t    alu_src2;
    core_pkg::word_t    data_mem_rd;
    core_pkg::word_t    mem_rdata;
    core_pkg::mem_req_t mem_req;

    always_comb begin
        case (ctrl_i.result_src)
            core_pkg::RES_ALU:     reg_wd = alu_out_o;
            core_pkg::RES_MEM:     reg_wd = data_mem_rd;    // loads
            core_pkg::RES_PC_NEXT: reg_wd = pc_next_i;      // jal link
            core_pkg::RES_IMM:     reg_wd = imm_ext_i;      // lui
            default:               reg_wd = '0;
        endcase
    end

    assign alu_src2 = ctrl_i.alu_src ? imm_ext_i : reg_rd2;

    register_file datapath_register_file (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .addr1_i    (ctrl_i.rs1),
        .addr2_i    (ctrl_i.rs2),
        .addr3_i    (ctrl_i.rd),
        .addr3_we_i (ctrl_i.reg_we),
        .trigger_i  (trigger_i),
        .addr3_wd_i (reg_wd),
        .rd1_o      (reg_rd1),
        .rd2_o      (reg_rd2),
        .a0_o       (a0_o)
    );

    alu datapath_alu (
        .src1_i        (reg_rd1),
        .src2_i        (alu_src2),
        .alu_control_i (ctrl_i.alu_control),
        .eq_o          (eq_o),
        .alu_result_o  (alu_out_o)
    );

    data_cache datapath_data_cache (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .cache_enable_i (cache_enable_i),
        .write_enable_i (ctrl_i.mem_we),
        .byte_op_i      (ctrl_i.mem_byte_op),
        .address_i      (alu_out_o),
        .write_data_i   (reg_rd2),
        .read_data_o    (data_mem_rd),
        .mem_req_o      (mem_req),
        .mem_rdata_i    (mem_rdata),
        .hits_o         (cache_hits_o)
    );

    data_memory datapath_data_memory (
        .clk_i     (clk_i),
        .mem_req_i (mem_req),
        .rdata_o   (mem_rdata)
    );

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input   logic                   clk_i,
    input   logic                   rst_n_i,
    input   core_pkg::reg_addr_t    addr1_i,
    input   core_pkg::reg_addr_t    addr2_i,
    input   core_pkg::reg_addr_t    addr3_i,
    input   logic                   addr3_we_i,
    input   logic                   trigger_i,
    input   core_pkg::word_t        addr3_wd_i,
    output  core_pkg::word_t        rd1_o,
    output  core_pkg::word_t        rd2_o,
    output  core_pkg::word_t        a0_o
);

    core_pkg::word_t    regs [1:31];    // x0 has no storage

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (addr3_we_i && (addr3_i != '0)) begin
                regs[addr3_i] <= addr3_wd_i;
            end
            // trigger ORs into a same-edge write of t0
            if (trigger_i) begin
                if (addr3_we_i && (addr3_i == core_pkg::T0_REG))
                    regs[core_pkg::T0_REG] <= addr3_wd_i | core_pkg::word_t'(1);
                else
                    regs[core_pkg::T0_REG][0] <= 1'b1;
            end
        end
    end

    assign rd1_o = (addr1_i == '0) ? '0 : regs[addr1_i];
    assign rd2_o = (addr2_i == '0) ? '0 : regs[addr2_i];
    assign a0_o  = regs[core_pkg::A0_REG];

endmodule
